/* common/vdma_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video read dma constants and shared types
// pixel and beat geometry with axi payload structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package vdma_pkg;

    // pixel and beat geometry
    localparam int PIX_W          = 24;
    localparam int AXI_DW         = 192;
    localparam int PIX_PER_BEAT   = 8;
    localparam int PIX_IDX_W      = 3;
    localparam int BYTES_PER_BEAT = 24;

    // axi read channel
    localparam int ADDR_W = 29;
    localparam int LEN_W  = 9;
    localparam int ID_W   = 4;
    localparam logic [ID_W-1:0] READ_ID       = '0;
    // 32 byte lanes with only the low 24 bytes carrying pixels
    localparam logic [2:0]      AR_SIZE       = 3'b101;
    localparam logic [1:0]      AR_BURST_INCR = 2'b01;

    // burst shaping
    localparam int BURST_BEATS  = 8;
    localparam int MAX_R_BURSTS = 3;
    localparam int BURST_CNT_W  = 3;
    // beats per frame fit in 29 bits for 16 bit hactive and vactive
    localparam int BEAT_CNT_W   = 29;

    // beat fifo
    localparam int FIFO_DEPTH       = 32;
    localparam int FIFO_PTR_W       = 5;
    localparam int FIFO_LVL_W       = 6;
    localparam int ALMOST_EMPTY_LVL = 4;

    typedef logic [PIX_W-1:0]      pix_t;
    typedef logic [AXI_DW-1:0]     beat_t;
    typedef logic [FIFO_LVL_W-1:0] lvl_t;

    // burst request from control to the read master
    typedef struct packed {
        logic [LEN_W-1:0] len;
        logic             tail;
    } ar_req_t;

    // len carries the beat count of the burst
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        beat_t           data;
        logic [1:0]      resp;
        logic            last;
    } axi_r_t;

endpackage

`default_nettype wire

/* hw/read_burst_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read burst control with frame beat accounting
// burst or tail choice and fifo space reservation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module read_burst_ctrl import vdma_pkg::*; (
    input  wire          clock,
    input  wire          rst_n,
    input  wire          enable,
    input  wire [15:0]   hactive,
    input  wire [15:0]   vactive,
    input  wire          frame_start,
    input  wire lvl_t    fifo_level,
    input  wire          beat_wr,
    input  wire          ar_idle,
    output ar_req_t      req,
    output logic         req_valid
);

    // beats still to be requested in this frame
    logic [BEAT_CNT_W-1:0] remaining;
    // beats requested but not yet written to the fifo
    lvl_t                  reserved;
    logic [31:0]           frame_pix;
    logic                  is_tail;
    logic [LEN_W-1:0]      cur_len;
    logic [LEN_W:0]        space_need;
    lvl_t                  add_beats;
    logic                  issue;

    // whole frame in pixels
    assign frame_pix = hactive * vactive;

    // short tail burst once fewer than a full burst remain
    assign is_tail = remaining < BEAT_CNT_W'(BURST_BEATS);
    assign cur_len = is_tail ? LEN_W'(remaining) : LEN_W'(BURST_BEATS);

    // stored beats plus reserved plus this burst must fit
    assign space_need = (LEN_W+1)'(fifo_level) + (LEN_W+1)'(reserved) + (LEN_W+1)'(cur_len);

    // one pulse per burst and only toward an idle AR channel
    assign issue = enable && (remaining != '0) && ar_idle && !req_valid && !frame_start
                   && (space_need <= (LEN_W+1)'(FIFO_DEPTH));

    assign add_beats = issue ? lvl_t'(cur_len) : lvl_t'(0);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            remaining <= '0;
            reserved  <= '0;
            req_valid <= 1'b0;
        end else if (frame_start) begin
            // new frame reloads the count
            // stale beats never reach the flushed fifo so the reservation restarts empty
            remaining <= BEAT_CNT_W'(frame_pix / PIX_PER_BEAT);
            reserved  <= '0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= issue;
            if (issue) begin
                remaining <= remaining - BEAT_CNT_W'(cur_len);
            end
            // grows by the burst length and shrinks one per written beat
            reserved <= reserved + add_beats - lvl_t'(beat_wr);
        end
    end

    // request payload alongside the pulse
    always_ff @(posedge clock) begin
        if (issue) begin
            req.len  <= cur_len;
            req.tail <= is_tail;
        end
    end

    // fifo contents plus reserved beats stay within the fifo depth
    a_space_ok: assert property (@(posedge clock) disable iff (!rst_n)
        ((FIFO_LVL_W+1)'(reserved) + (FIFO_LVL_W+1)'(fifo_level))
            <= (FIFO_LVL_W+1)'(FIFO_DEPTH));

    // the master must still be idle while the pulse is up
    a_req_idle: assert property (@(posedge clock) disable iff (!rst_n)
        req_valid |-> ar_idle);

endmodule

`default_nettype wire

/* hw/axi_read/axi_read_master.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// axi read master with frame address generation
// AR channel driver and R beat acceptance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module axi_read_master import vdma_pkg::*; (
    input  wire              clock,
    input  wire              rst_n,
    input  wire              frame_start,
    input  wire [ADDR_W-1:0] baseaddr,
    input  wire ar_req_t     req,
    input  wire              req_valid,
    input  wire              arready,
    input  wire axi_r_t      r,
    input  wire              rvalid,
    output logic             ar_idle,
    output axi_ar_t          ar,
    output logic             arvalid,
    output logic             rready,
    output logic             beat_wr,
    output beat_t            beat
);

    // address of the next burst in the frame
    logic [ADDR_W-1:0]      next_addr;
    // bursts accepted on AR whose rlast is still to come
    logic [BURST_CNT_W-1:0] r_bursts;
    // bursts of an abandoned frame still to drain
    logic [BURST_CNT_W-1:0] stale;
    logic                   tail_seen;
    logic                   ar_done;
    logic                   r_end;

    // space is reserved before each request so R is never stalled
    assign rready = 1'b1;

    assign ar_done = arvalid && arready;
    assign r_end   = rvalid && rready && r.last;

    // no pending AR and room for one more burst on R
    assign ar_idle = !arvalid && (r_bursts < BURST_CNT_W'(MAX_R_BURSTS));

    // beats of an old frame are dropped
    assign beat_wr = rvalid && rready && (stale == '0) && !frame_start;
    assign beat    = r.data;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            arvalid   <= 1'b0;
            next_addr <= '0;
            r_bursts  <= '0;
            stale     <= '0;
            tail_seen <= 1'b0;
        end else begin
            if (req_valid) begin
                arvalid <= 1'b1;
            end else if (ar_done) begin
                arvalid <= 1'b0;
            end

            // frame base wins over the running address
            if (frame_start) begin
                next_addr <= baseaddr;
            end else if (req_valid) begin
                next_addr <= next_addr + ADDR_W'(req.len * BYTES_PER_BEAT);
            end

            r_bursts <= r_bursts + BURST_CNT_W'(ar_done) - BURST_CNT_W'(r_end);

            // everything in flight at frame start belongs to the old frame
            if (frame_start) begin
                stale <= r_bursts + BURST_CNT_W'(arvalid) + BURST_CNT_W'(req_valid)
                         - BURST_CNT_W'(r_end);
            end else if (r_end && (stale != '0)) begin
                stale <= stale - 1'b1;
            end

            if (frame_start) begin
                tail_seen <= 1'b0;
            end else if (req_valid && req.tail) begin
                tail_seen <= 1'b1;
            end
        end
    end

    // AR payload captured with the request and held until accepted
    always_ff @(posedge clock) begin
        if (req_valid) begin
            ar <= '{id: READ_ID, addr: next_addr, len: req.len,
                    size: AR_SIZE, burst: AR_BURST_INCR};
        end
    end

    // AR payload holds steady under back-pressure
    a_ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar));

    // a tail burst closes the frame
    a_tail_last: assert property (@(posedge clock) disable iff (!rst_n)
        req_valid |-> !tail_seen);

endmodule

`default_nettype wire

/* hw/stream_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// synchronous beat fifo with show-ahead output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module stream_fifo import vdma_pkg::*; (
    input  wire         clock,
    input  wire         rst_n,
    input  wire         flush,
    input  wire         wr,
    input  wire beat_t  din,
    input  wire         rd,
    output beat_t       dout,
    output logic        empty,
    output lvl_t        level,
    output logic        almost_empty
);

    beat_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  full;
    logic                  do_wr;
    logic                  do_rd;

    assign full         = level == lvl_t'(FIFO_DEPTH);
    assign empty        = level == '0;
    assign almost_empty = level <= lvl_t'(ALMOST_EMPTY_LVL);

    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    // head entry visible without a read
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            // pointers wrap naturally at the depth
            wr_ptr <= wr_ptr + FIFO_PTR_W'(do_wr);
            rd_ptr <= rd_ptr + FIFO_PTR_W'(do_rd);
            level  <= level + lvl_t'(do_wr) - lvl_t'(do_rd);
        end
    end

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    a_no_overflow: assert property (@(posedge clock) disable iff (!rst_n)
        wr && !flush |-> !full);

    a_no_underflow: assert property (@(posedge clock) disable iff (!rst_n)
        rd && !flush |-> !empty);

endmodule

`default_nettype wire

/* hw/destruct_data.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// beat to pixel splitter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module destruct_data import vdma_pkg::*; (
    input  wire         clock,
    input  wire         rst_n,
    input  wire         frame_start,
    input  wire beat_t  fifo_dout,
    input  wire         fifo_empty,
    input  wire         pix_rd,
    output logic        fifo_rd,
    output pix_t        pix
);

    // current beat and next pixel within it
    beat_t                hold;
    logic                 hold_valid;
    logic [PIX_IDX_W-1:0] idx;
    logic                 last_pix;

    // final pixel of the held beat goes out this cycle
    assign last_pix = pix_rd && hold_valid && (idx == PIX_IDX_W'(PIX_PER_BEAT - 1));

    // refill when empty or emptying
    // nothing is popped in the flush cycle
    assign fifo_rd = !frame_start && !fifo_empty && (!hold_valid || last_pix);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
            idx        <= '0;
        end else if (frame_start) begin
            // drop any beat of the previous frame
            hold_valid <= 1'b0;
            idx        <= '0;
        end else if (fifo_rd) begin
            hold_valid <= 1'b1;
            idx        <= '0;
        end else if (last_pix) begin
            hold_valid <= 1'b0;
        end else if (pix_rd && hold_valid) begin
            idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fifo_rd) begin
            hold <= fifo_dout;
        end
    end

    // pixel j sits at bits j*24 upward
    always_ff @(posedge clock) begin
        if (pix_rd) begin
            pix <= hold[PIX_W*idx +: PIX_W];
        end
    end

endmodule

`default_nettype wire

/* hw/video_out_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// native video output port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module video_out_port import vdma_pkg::*; (
    input  wire         clock,
    input  wire         rst_n,
    input  wire         in_vsync,
    input  wire         in_hsync,
    input  wire         in_de,
    input  wire pix_t   pix,
    output logic        frame_start,
    output logic        pix_rd,
    output logic        out_vsync,
    output logic        out_hsync,
    output logic        out_de,
    output pix_t        odata
);

    typedef struct packed {
        logic vsync;
        logic hsync;
        logic de;
    } sync_t;

    logic  vsync_q;
    sync_t sync_d1;
    sync_t sync_d2;

    // one pixel per active cycle
    assign pix_rd = in_de;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            vsync_q     <= 1'b0;
            frame_start <= 1'b0;
            sync_d1     <= '0;
            sync_d2     <= '0;
        end else begin
            vsync_q     <= in_vsync;
            // vsync rising edge
            frame_start <= in_vsync && !vsync_q;
            sync_d1     <= '{vsync: in_vsync, hsync: in_hsync, de: in_de};
            sync_d2     <= sync_d1;
        end
    end

    // pixel arrives one cycle after pix_rd and lines up with stage two
    always_ff @(posedge clock) begin
        odata <= pix;
    end

    assign out_vsync = sync_d2.vsync;
    assign out_hsync = sync_d2.hsync;
    assign out_de    = sync_d2.de;

endmodule

`default_nettype wire

/* hw/mm_rev.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video read dma top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mm_rev import vdma_pkg::*; (
    input  wire              clock,
    input  wire              rst_n,
    input  wire              enable,
    input  wire [ADDR_W-1:0] baseaddr,
    input  wire [15:0]       hactive,
    input  wire [15:0]       vactive,
    input  wire              in_vsync,
    input  wire              in_hsync,
    input  wire              in_de,
    input  wire              axi_arready,
    input  wire axi_r_t      axi_r,
    input  wire              axi_rvalid,
    output wire axi_ar_t     axi_ar,
    output wire              axi_arvalid,
    output wire              axi_rready,
    output wire              fifo_almost_empty,
    output wire              out_vsync,
    output wire              out_hsync,
    output wire              out_de,
    output wire pix_t        odata
);

    // frame start and pixel path
    logic    frame_start;
    logic    pix_rd;
    pix_t    pix;
    logic    fifo_rd;
    logic    fifo_empty;
    beat_t   fifo_dout;
    lvl_t    fifo_level;
    // read request path
    logic    beat_wr;
    beat_t   beat;
    logic    ar_idle;
    ar_req_t req;
    logic    req_valid;

    video_out_port video_out_port_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_vsync    (in_vsync),
        .in_hsync    (in_hsync),
        .in_de       (in_de),
        .pix         (pix),
        .frame_start (frame_start),
        .pix_rd      (pix_rd),
        .out_vsync   (out_vsync),
        .out_hsync   (out_hsync),
        .out_de      (out_de),
        .odata       (odata)
    );

    destruct_data destruct_data_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .fifo_dout   (fifo_dout),
        .fifo_empty  (fifo_empty),
        .pix_rd      (pix_rd),
        .fifo_rd     (fifo_rd),
        .pix         (pix)
    );

    // flushed at every frame start
    stream_fifo stream_fifo_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .flush        (frame_start),
        .wr           (beat_wr),
        .din          (beat),
        .rd           (fifo_rd),
        .dout         (fifo_dout),
        .empty        (fifo_empty),
        .level        (fifo_level),
        .almost_empty (fifo_almost_empty)
    );

    read_burst_ctrl read_burst_ctrl_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .enable      (enable),
        .hactive     (hactive),
        .vactive     (vactive),
        .frame_start (frame_start),
        .fifo_level  (fifo_level),
        .beat_wr     (beat_wr),
        .ar_idle     (ar_idle),
        .req         (req),
        .req_valid   (req_valid)
    );

    axi_read_master axi_read_master_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .baseaddr    (baseaddr),
        .req         (req),
        .req_valid   (req_valid),
        .arready     (axi_arready),
        .r           (axi_r),
        .rvalid      (axi_rvalid),
        .ar_idle     (ar_idle),
        .ar          (axi_ar),
        .arvalid     (axi_arvalid),
        .rready      (axi_rready),
        .beat_wr     (beat_wr),
        .beat        (beat)
    );

endmodule

`default_nettype wire

/* test/axi_mem_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// axi read slave for simulation
// computed pixel pattern, random arready delay, AR log
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model import vdma_pkg::*; #(
    parameter logic [31:0] SEED = 32'h0
) (
    input  wire          clock,
    input  wire          rst_n,
    input  wire axi_ar_t ar,
    input  wire          arvalid,
    output logic         arready,
    output axi_r_t       r,
    output logic         rvalid,
    input  wire          rready
);

    localparam int LOG_DEPTH = 64;
    localparam int MAX_WAIT  = 5;
    localparam int PIX_BYTES = PIX_W / 8;

    // every accepted request for the testbench
    axi_ar_t ar_log [LOG_DEPTH];
    int      ar_count = 0;
    // accepted bursts whose beats are still owed
    axi_ar_t pend [$];
    int      beat_idx;
    int      wait_cnt;

    // pixel at byte address a is a[23:0] xor 5a5a5a
    function automatic beat_t beat_at(logic [ADDR_W-1:0] addr);
        beat_t             b;
        logic [ADDR_W-1:0] a;
        for (int j = 0; j < PIX_PER_BEAT; j++) begin
            a = addr + ADDR_W'(j * PIX_BYTES);
            b[j*PIX_W +: PIX_W] = a[23:0] ^ 24'h5a5a5a;
        end
        return b;
    endfunction

    initial begin
        // arready delays drawn from this process
        void'($urandom(SEED));
        arready  = 1'b0;
        rvalid   = 1'b0;
        r        = '0;
        beat_idx = 0;
        wait_cnt = -1;
        forever begin
            @(posedge clock);
            if (!rst_n) begin
                pend.delete();
                ar_count = 0;
                beat_idx = 0;
                wait_cnt = -1;
                #1;
                arready = 1'b0;
                rvalid  = 1'b0;
            end else begin
                // handshakes seen at this edge
                if (arvalid && arready) begin
                    pend.push_back(ar);
                    if (ar_count < LOG_DEPTH) begin
                        ar_log[ar_count] = ar;
                    end
                    ar_count++;
                end
                if (rvalid && rready) begin
                    if (r.last) begin
                        void'(pend.pop_front());
                        beat_idx = 0;
                    end else begin
                        beat_idx++;
                    end
                end
                #1;
                // arready after a random wait of 0 to 5 cycles
                if (arready) begin
                    arready = 1'b0;
                end else if (arvalid) begin
                    if (wait_cnt < 0) begin
                        wait_cnt = int'($urandom_range(MAX_WAIT, 0));
                    end
                    if (wait_cnt == 0) begin
                        arready  = 1'b1;
                        wait_cnt = -1;
                    end else begin
                        wait_cnt--;
                    end
                end
                // len holds the beat count of the burst
                if (pend.size() > 0) begin
                    rvalid = 1'b1;
                    r = '{id: pend[0].id,
                          data: beat_at(pend[0].addr + ADDR_W'(beat_idx * BYTES_PER_BEAT)),
                          resp: 2'b00,
                          last: (beat_idx == int'(pend[0].len) - 1)};
                end else begin
                    rvalid = 1'b0;
                    r.last = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_mm_rev.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the video read dma
// directed frame tests, compare tasks, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_mm_rev import vdma_pkg::*; ();

    localparam int          CLK_PERIOD = 40;
    localparam int          RST_CYCLES = 4;
    localparam int          DRV_DLY    = 2;
    localparam logic [31:0] SEED       = 32'he9db;
    // video timing in clock cycles
    localparam int VS_CYC    = 4;
    localparam int BLANK_CYC = 60;
    localparam int HS_CYC    = 2;
    localparam int PORCH_CYC = 3;
    localparam int DRAIN_CYC = 4;
    localparam int GATE_CYC  = 50;
    localparam int PIX_BYTES = PIX_W / 8;

    typedef struct packed {
        logic vsync;
        logic hsync;
        logic de;
    } vid_sync_t;

    logic              clock = 1'b0;
    logic              rst_n;
    logic              enable;
    logic [ADDR_W-1:0] baseaddr;
    logic [15:0]       hactive;
    logic [15:0]       vactive;
    logic              in_vsync;
    logic              in_hsync;
    logic              in_de;
    logic              axi_arready;
    axi_r_t            axi_r;
    logic              axi_rvalid;
    axi_ar_t           axi_ar;
    logic              axi_arvalid;
    logic              axi_rready;
    logic              fifo_almost_empty;
    logic              out_vsync;
    logic              out_hsync;
    logic              out_de;
    pix_t              odata;

    // expected pixel stream and AR log position of the current frame
    logic [ADDR_W-1:0] exp_base = '0;
    int                exp_idx = 0;
    int                ar_mark = 0;
    int                error_count = 0;
    logic              mon_on = 1'b0;
    vid_sync_t         sync_hist [2] = '{default: '0};

    always #(CLK_PERIOD / 2) clock = ~clock;

    mm_rev DUT (
        .clock             (clock),
        .rst_n             (rst_n),
        .enable            (enable),
        .baseaddr          (baseaddr),
        .hactive           (hactive),
        .vactive           (vactive),
        .in_vsync          (in_vsync),
        .in_hsync          (in_hsync),
        .in_de             (in_de),
        .axi_arready       (axi_arready),
        .axi_r             (axi_r),
        .axi_rvalid        (axi_rvalid),
        .axi_ar            (axi_ar),
        .axi_arvalid       (axi_arvalid),
        .axi_rready        (axi_rready),
        .fifo_almost_empty (fifo_almost_empty),
        .out_vsync         (out_vsync),
        .out_hsync         (out_hsync),
        .out_de            (out_de),
        .odata             (odata)
    );

    axi_mem_model #(.SEED(SEED)) mem_model (
        .clock   (clock),
        .rst_n   (rst_n),
        .ar      (axi_ar),
        .arvalid (axi_arvalid),
        .arready (axi_arready),
        .r       (axi_r),
        .rvalid  (axi_rvalid),
        .rready  (axi_rready)
    );

    task automatic stop_on_error(string msg);
        error_count++;
        $display("Error: time %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "mismatch");
    endtask

    task automatic check_pix(pix_t got, pix_t exp, string what);
        if (got !== exp) begin
            stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_ar(axi_ar_t got, axi_ar_t exp, string what);
        string got_s;
        string exp_s;
        if (got !== exp) begin
            got_s = $sformatf("id %h addr %h len %0d size %b burst %b",
                              got.id, got.addr, got.len, got.size, got.burst);
            exp_s = $sformatf("id %h addr %h len %0d size %b burst %b",
                              exp.id, exp.addr, exp.len, exp.size, exp.burst);
            stop_on_error($sformatf("%s got %s, expected %s", what, got_s, exp_s));
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            stop_on_error($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) begin
            stop_on_error($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    // memory pattern for the pixel at byte address a
    function automatic pix_t pattern_pix(logic [ADDR_W-1:0] a);
        return a[23:0] ^ 24'h5a5a5a;
    endfunction

    function automatic axi_ar_t expect_ar(logic [ADDR_W-1:0] a, int len);
        return '{id: READ_ID, addr: a, len: LEN_W'(len), size: AR_SIZE, burst: AR_BURST_INCR};
    endfunction

    function automatic int frame_cycles(int h, int v);
        return VS_CYC + BLANK_CYC + v * (HS_CYC + 2 * PORCH_CYC + h) + DRAIN_CYC;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #DRV_DLY;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) next_cycle();
    endtask

    // frame geometry set up before the vsync edge
    task automatic start_frame(logic [ADDR_W-1:0] base, int h, int v);
        baseaddr = base;
        hactive  = 16'(h);
        vactive  = 16'(v);
        exp_base = base;
        exp_idx  = 0;
        ar_mark  = mem_model.ar_count;
        in_vsync = 1'b1;
        idle_cycles(VS_CYC);
        in_vsync = 1'b0;
    endtask

    task automatic play_lines(int h, int v);
        for (int line = 0; line < v; line++) begin
            in_hsync = 1'b1;
            idle_cycles(HS_CYC);
            in_hsync = 1'b0;
            idle_cycles(PORCH_CYC);
            in_de = 1'b1;
            idle_cycles(h);
            in_de = 1'b0;
            idle_cycles(PORCH_CYC);
        end
        idle_cycles(DRAIN_CYC);
    endtask

    // pixel count and burst sequence of a finished frame
    task automatic check_frame(logic [ADDR_W-1:0] base, int h, int v);
        int beats;
        int left;
        int len;
        int k;
        beats = h * v / PIX_PER_BEAT;
        check_count(exp_idx, h * v, "pixels out");
        // every beat of the frame has been read out
        check_bit(fifo_almost_empty, 1'b1, "fifo_almost_empty after frame");
        check_count(mem_model.ar_count - ar_mark, (beats + BURST_BEATS - 1) / BURST_BEATS,
                    "AR requests");
        left = beats;
        k    = 0;
        while (left > 0) begin
            len = (left < BURST_BEATS) ? left : BURST_BEATS;
            check_ar(mem_model.ar_log[ar_mark + k],
                     expect_ar(base + ADDR_W'(k * BURST_BEATS * BYTES_PER_BEAT), len),
                     "AR request");
            left -= len;
            k++;
        end
    endtask

    task automatic run_frame(logic [ADDR_W-1:0] base, int h, int v);
        start_frame(base, h, v);
        idle_cycles(BLANK_CYC);
        // the whole frame is buffered by the end of blanking
        check_bit(fifo_almost_empty, 1'b0, "fifo_almost_empty after blanking");
        play_lines(h, v);
        check_frame(base, h, v);
    endtask

    task automatic test_reset();
        rst_n = 1'b0;
        for (int i = 0; i < RST_CYCLES; i++) begin
            next_cycle();
            check_bit(axi_arvalid, 1'b0, "axi_arvalid in reset");
            check_bit(out_de, 1'b0, "out_de in reset");
        end
        rst_n = 1'b1;
        for (int i = 0; i < RST_CYCLES; i++) begin
            next_cycle();
            check_bit(axi_arvalid, 1'b0, "axi_arvalid after reset");
            check_bit(out_de, 1'b0, "out_de after reset");
            check_bit(axi_rready, 1'b1, "axi_rready after reset");
            check_bit(fifo_almost_empty, 1'b1, "fifo_almost_empty after reset");
        end
        mon_on = 1'b1;
    endtask

    // 16 beats as two full bursts
    task automatic test_full_frame();
        run_frame(29'h0010000, 32, 4);
    endtask

    // 15 beats end with a 7 beat tail
    task automatic test_tail_burst();
        run_frame(29'h0023400, 40, 3);
    endtask

    task automatic test_enable_gating();
        enable = 1'b0;
        start_frame(29'h0031200, 32, 4);
        for (int i = 0; i < GATE_CYC; i++) begin
            next_cycle();
            check_bit(axi_arvalid, 1'b0, "axi_arvalid while disabled");
        end
        check_count(mem_model.ar_count - ar_mark, 0, "AR requests while disabled");
        enable = 1'b1;
        idle_cycles(BLANK_CYC);
        play_lines(32, 4);
        check_frame(29'h0031200, 32, 4);
    endtask

    // one line of a frame, then vsync with a new base
    task automatic test_frame_restart();
        start_frame(29'h0040000, 32, 4);
        idle_cycles(BLANK_CYC);
        play_lines(32, 1);
        check_count(exp_idx, 32, "pixels before restart");
        run_frame(29'h0058800, 32, 4);
    endtask

    // sync delay and pixel stream checked on the falling edge
    always @(negedge clock) begin
        if (mon_on) begin
            check_bit(out_vsync, sync_hist[1].vsync, "out_vsync");
            check_bit(out_hsync, sync_hist[1].hsync, "out_hsync");
            check_bit(out_de, sync_hist[1].de, "out_de");
            if (out_de) begin
                check_pix(odata, pattern_pix(exp_base + ADDR_W'(PIX_BYTES * exp_idx)), "odata");
                exp_idx++;
            end
        end
        sync_hist[1] = sync_hist[0];
        sync_hist[0] = '{vsync: in_vsync, hsync: in_hsync, de: in_de};
    end

    initial begin : watchdog
        int budget;
        budget = 2 * (2 * RST_CYCLES + frame_cycles(32, 4) + frame_cycles(40, 3)
                 + GATE_CYC + frame_cycles(32, 4) + frame_cycles(32, 1) + frame_cycles(32, 4));
        repeat (budget) @(posedge clock);
        $display("timeout: the tests did not finish within %0d cycles", budget);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        rst_n    = 1'b0;
        enable   = 1'b1;
        baseaddr = '0;
        hactive  = '0;
        vactive  = '0;
        in_vsync = 1'b0;
        in_hsync = 1'b0;
        in_de    = 1'b0;
        test_reset();
        test_full_frame();
        test_tail_burst();
        test_enable_gating();
        test_frame_restart();
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
common/vdma_pkg.sv
hw/read_burst_ctrl.sv
hw/axi_read/axi_read_master.sv
hw/stream_fifo.sv
hw/destruct_data.sv
hw/video_out_port.sv
hw/mm_rev.sv
test/axi_mem_model.sv
test/tb_mm_rev.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mm_rev
FILELIST   := files.f
OBJDIR     := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: build
	-./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
